// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_axi_write_bridge
FILELIST := axi_write_bridge.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@! grep -q "Regression failed" $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: axi_write_bridge.f
design/axi_write_bridge_pkg.sv
design/write_req_if.sv
design/apb_write_sequencer.sv
design/aw_channel.sv
design/w_channel.sv
design/b_channel.sv
design/axi_write_bridge.sv
sim/tb_axi_write_bridge.sv

// File: design/apb_write_sequencer.sv
/* APB write sequencer */

`timescale 1ns/1ps

module apb_write_sequencer (
    input  logic        clock,
    input  logic        rst_n,

    // APB control
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,

    write_req_if.ctrl   req,

    // Channel enable/done pairs
    output logic        aw_enable,
    output logic        w_enable,
    output logic        b_enable,
    input  logic        aw_done,
    input  logic        w_done,
    input  logic        b_done,

    // Registered error flag from the B channel
    input  logic        resp_error,

    // APB completion
    output logic        pready,
    output logic        pslverr
);

    axi_write_bridge_pkg::seq_state_t state;
    axi_write_bridge_pkg::seq_state_t state_next;

    logic access;
    // Transfer in flight is a write
    logic is_write;

    // APB access phase
    assign access = psel && penable;

    // --------------------
    // State register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state    <= axi_write_bridge_pkg::IDLE;
            is_write <= 1'b0;
        end else begin
            state <= state_next;
            if (state == axi_write_bridge_pkg::IDLE && access) begin
                is_write <= pwrite;
            end
        end
    end

    // --------------------
    // Next state
    // Strict order of address, data and response
    always_comb begin
        state_next = state;
        case (state)
            axi_write_bridge_pkg::IDLE: begin
                if (access) begin
                    // Reads skip the AXI side entirely
                    state_next = pwrite ? axi_write_bridge_pkg::DO_ADDR
                                        : axi_write_bridge_pkg::FINISH;
                end
            end
            axi_write_bridge_pkg::DO_ADDR: begin
                if (aw_done) state_next = axi_write_bridge_pkg::DO_DATA;
            end
            axi_write_bridge_pkg::DO_DATA: begin
                if (w_done) state_next = axi_write_bridge_pkg::DO_RESP;
            end
            axi_write_bridge_pkg::DO_RESP: begin
                if (b_done) state_next = axi_write_bridge_pkg::FINISH;
            end
            axi_write_bridge_pkg::FINISH: begin
                // One cycle of pready
                state_next = axi_write_bridge_pkg::IDLE;
            end
            default: state_next = axi_write_bridge_pkg::IDLE;
        endcase
    end

    // --------------------
    // Outputs decoded from state
    assign req.capture = (state == axi_write_bridge_pkg::IDLE) && access && pwrite;

    assign aw_enable = (state == axi_write_bridge_pkg::DO_ADDR);
    assign w_enable  = (state == axi_write_bridge_pkg::DO_DATA);
    assign b_enable  = (state == axi_write_bridge_pkg::DO_RESP);

    assign pready  = (state == axi_write_bridge_pkg::FINISH);
    // Reads always fail
    assign pslverr = pready && (!is_write || resp_error);

    // Done only from the channel whose state is active
    assert property (@(posedge clock) disable iff (!rst_n)
        ({aw_done, w_done, b_done} & ~{aw_enable, w_enable, b_enable}) == 3'b000);

    // Completion only while the APB access is held
    assert property (@(posedge clock) disable iff (!rst_n)
        pready |-> psel && penable);

endmodule

// File: design/aw_channel.sv
/* AXI write address channel */

`timescale 1ns/1ps

module aw_channel (
    input  logic                        clock,
    input  logic                        rst_n,

    write_req_if.chan                   req,

    // Sequencer handshake
    input  logic                        enable,
    output logic                        done,

    // AXI AW
    output logic                        awvalid,
    input  logic                        awready,
    output axi_write_bridge_pkg::addr_t awaddr
);

    // Payload register, loaded once per request
    always_ff @(posedge clock) begin
        if (req.capture) begin
            awaddr <= req.addr;
        end
    end

    // --------------------
    // Valid control
    // Raised the cycle after enable, dropped on the handshake
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            awvalid <= 1'b0;
        end else if (awvalid && awready) begin
            awvalid <= 1'b0;
        end else if (enable && !awvalid) begin
            awvalid <= 1'b1;
        end
    end

    // Handshake cycle
    assign done = awvalid && awready;

    // Address held while slave stalls
    assert property (@(posedge clock) disable iff (!rst_n)
        awvalid && !awready |=> $stable(awaddr));

endmodule

// File: design/axi_write_bridge.sv
/* APB to AXI4-Lite write bridge */

`timescale 1ns/1ps

module axi_write_bridge (
    input  logic                        clock,
    input  logic                        rst_n,

    // APB slave
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  axi_write_bridge_pkg::addr_t paddr,
    input  axi_write_bridge_pkg::data_t pwdata,
    input  axi_write_bridge_pkg::strb_t pstrb,
    output logic                        pready,
    output logic                        pslverr,
    output axi_write_bridge_pkg::data_t prdata,

    // AXI4-Lite write master
    output logic                        awvalid,
    input  logic                        awready,
    output axi_write_bridge_pkg::addr_t awaddr,
    output logic                        wvalid,
    input  logic                        wready,
    output axi_write_bridge_pkg::data_t wdata,
    output axi_write_bridge_pkg::strb_t wstrb,
    input  logic                        bvalid,
    output logic                        bready,
    input  axi_write_bridge_pkg::resp_t bresp
);

    logic aw_enable;
    logic w_enable;
    logic b_enable;
    logic aw_done;
    logic w_done;
    logic b_done;
    logic resp_error;

    // --------------------
    // Request straight from APB
    write_req_if req ();

    assign req.addr = paddr;
    assign req.data = pwdata;
    assign req.strb = pstrb;

    // No read path
    assign prdata = '0;

    apb_write_sequencer u_sequencer (
        .clock      (clock),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .req        (req.ctrl),
        .aw_enable  (aw_enable),
        .w_enable   (w_enable),
        .b_enable   (b_enable),
        .aw_done    (aw_done),
        .w_done     (w_done),
        .b_done     (b_done),
        .resp_error (resp_error),
        .pready     (pready),
        .pslverr    (pslverr)
    );

    // --------------------
    // One driver per AXI channel
    aw_channel u_aw_channel (
        .clock   (clock),
        .rst_n   (rst_n),
        .req     (req.chan),
        .enable  (aw_enable),
        .done    (aw_done),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr)
    );

    w_channel u_w_channel (
        .clock  (clock),
        .rst_n  (rst_n),
        .req    (req.chan),
        .enable (w_enable),
        .done   (w_done),
        .wvalid (wvalid),
        .wready (wready),
        .wdata  (wdata),
        .wstrb  (wstrb)
    );

    b_channel u_b_channel (
        .clock      (clock),
        .rst_n      (rst_n),
        .enable     (b_enable),
        .done       (b_done),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .resp_error (resp_error)
    );

endmodule

// File: design/axi_write_bridge_pkg.sv
/* APB to AXI4-Lite write bridge definitions */

package axi_write_bridge_pkg;

    // --------------------
    // Bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    // One strobe bit per data byte
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [1:0]            resp_t;

    // --------------------
    // AXI response codes, upper bit set means error
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_EXOKAY = 2'b01;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE,
        DO_ADDR,
        DO_DATA,
        DO_RESP,
        FINISH
    } seq_state_t;

endpackage

// File: design/b_channel.sv
/* AXI write response channel */

`timescale 1ns/1ps

module b_channel (
    input  logic                        clock,
    input  logic                        rst_n,

    // Sequencer handshake
    input  logic                        enable,
    output logic                        done,

    // AXI B
    input  logic                        bvalid,
    output logic                        bready,
    input  axi_write_bridge_pkg::resp_t bresp,

    // Error from the last response
    output logic                        resp_error
);

    // --------------------
    // Ready control
    // Up one cycle after enable, down after the handshake
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            bready <= 1'b0;
        end else if (bvalid && bready) begin
            bready <= 1'b0;
        end else if (enable && !bready) begin
            bready <= 1'b1;
        end
    end

    assign done = bvalid && bready;

    // --------------------
    // Error flag, SLVERR and DECERR both count
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            resp_error <= 1'b0;
        end else if (done) begin
            resp_error <= bresp[1];
        end
    end

    // Response only taken in the sequencer's response state
    assert property (@(posedge clock) disable iff (!rst_n)
        bvalid && bready |-> enable);

endmodule

// File: design/w_channel.sv
/* AXI write data channel */

`timescale 1ns/1ps

module w_channel (
    input  logic                        clock,
    input  logic                        rst_n,

    write_req_if.chan                   req,

    // Sequencer handshake
    input  logic                        enable,
    output logic                        done,

    // AXI W
    output logic                        wvalid,
    input  logic                        wready,
    output axi_write_bridge_pkg::data_t wdata,
    output axi_write_bridge_pkg::strb_t wstrb
);

    // --------------------
    // Payload registers
    always_ff @(posedge clock) begin
        if (req.capture) begin
            wdata <= req.data;
            wstrb <= req.strb;
        end
    end

    // --------------------
    // Valid control
    // Same rule as the address channel
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wvalid <= 1'b0;
        end else if (wvalid && wready) begin
            wvalid <= 1'b0;
        end else if (enable && !wvalid) begin
            wvalid <= 1'b1;
        end
    end

    assign done = wvalid && wready;

    // Payload held while stalled
    assert property (@(posedge clock) disable iff (!rst_n)
        wvalid && !wready |=> $stable(wdata) && $stable(wstrb));

    // APB side must not send an empty write
    assert property (@(posedge clock) disable iff (!rst_n)
        wvalid |-> wstrb != '0);

endmodule

// File: design/write_req_if.sv
/* Captured write request */

`timescale 1ns/1ps

interface write_req_if;

    // Request payload, straight from the APB side
    axi_write_bridge_pkg::addr_t addr;
    axi_write_bridge_pkg::data_t data;
    axi_write_bridge_pkg::strb_t strb;

    // Load strobe for the channel payload registers
    logic capture;

    // Sequencer side
    modport ctrl (
        output capture
    );

    // Channel side
    modport chan (
        input addr,
        input data,
        input strb,
        input capture
    );

endinterface

// File: sim/tb_axi_write_bridge.sv
/* APB to AXI write bridge testbench */

`timescale 1ns/1ps

module tb_axi_write_bridge;

    localparam int TIMEOUT_CYCLES = 40 * 30;

    logic                        clock;
    logic                        rst_n;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    axi_write_bridge_pkg::addr_t paddr;
    axi_write_bridge_pkg::data_t pwdata;
    axi_write_bridge_pkg::strb_t pstrb;
    logic                        pready;
    logic                        pslverr;
    axi_write_bridge_pkg::data_t prdata;
    logic                        awvalid;
    logic                        awready;
    axi_write_bridge_pkg::addr_t awaddr;
    logic                        wvalid;
    logic                        wready;
    axi_write_bridge_pkg::data_t wdata;
    axi_write_bridge_pkg::strb_t wstrb;
    logic                        bvalid;
    logic                        bready;
    axi_write_bridge_pkg::resp_t bresp;

    // Slave side record of accepted beats
    axi_write_bridge_pkg::addr_t seen_addr;
    axi_write_bridge_pkg::data_t seen_data;
    axi_write_bridge_pkg::strb_t seen_strb;
    int aw_count = 0;
    int aw_cycle = 0;
    int w_cycle = 0;
    int b_cycle = 0;
    int pready_cycle = 0;

    int          cycle = 0;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [31:0] lcg_state = 32'h14366c1c;

    axi_write_bridge DUT (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // --------------------
    // Helpers
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Upper bits, the low ones repeat too soon
    function automatic int rand_delay();
        logic [31:0] r;
        r = lcg_next();
        return int'(r[17:16]);
    endfunction

    function automatic axi_write_bridge_pkg::resp_t response_for(
        input axi_write_bridge_pkg::addr_t a);
        if (a[31] && a[30]) return axi_write_bridge_pkg::RESP_DECERR;
        if (a[31]) return axi_write_bridge_pkg::RESP_SLVERR;
        return axi_write_bridge_pkg::RESP_OKAY;
    endfunction

    // Lands 2 ns after the edge
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #2;
        end
    endtask

    // --------------------
    // AXI slave model
    initial begin : aw_slave
        int delay;
        awready = 1'b0;
        forever begin
            @(negedge clock);
            if (awvalid) begin
                delay = rand_delay();
                wait_cycles(delay + 1);
                awready = 1'b1;
                wait_cycles(1);
                awready = 1'b0;
            end
        end
    end

    initial begin : w_b_slave
        int delay;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp  = axi_write_bridge_pkg::RESP_OKAY;
        forever begin
            @(negedge clock);
            if (wvalid) begin
                delay = rand_delay();
                wait_cycles(delay + 1);
                wready = 1'b1;
                wait_cycles(1);
                wready = 1'b0;
                // Response gap after W
                delay = rand_delay();
                wait_cycles(delay);
                bresp  = response_for(seen_addr);
                bvalid = 1'b1;
                @(negedge clock);
                while (!bready) @(negedge clock);
                wait_cycles(1);
                bvalid = 1'b0;
            end
        end
    end

    // Handshakes sampled mid-cycle
    always @(negedge clock) begin
        if (awvalid && awready) begin
            seen_addr <= awaddr;
            aw_count  <= aw_count + 1;
            aw_cycle  <= cycle;
        end
        if (wvalid && wready) begin
            seen_data <= wdata;
            seen_strb <= wstrb;
            w_cycle   <= cycle;
        end
        if (bvalid && bready) b_cycle <= cycle;
        if (pready) pready_cycle <= cycle;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a transfer never completed", cycle);
            $display("Regression failed");
            $finish;
        end
    end

    // --------------------
    // Compare tasks
    task automatic compare_addr(input string name, input axi_write_bridge_pkg::addr_t actual,
                                input axi_write_bridge_pkg::addr_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h",
                     $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic compare_data(input string name, input axi_write_bridge_pkg::data_t actual,
                                input axi_write_bridge_pkg::data_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h",
                     $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic compare_strb(input string name, input axi_write_bridge_pkg::strb_t actual,
                                input axi_write_bridge_pkg::strb_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got 4'b%04b expected 4'b%04b",
                     $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAILED, %0d mismatches", name, errors - start_errors);
        end
    endtask

    // --------------------
    // APB master
    task automatic apb_transfer(input logic write, input axi_write_bridge_pkg::addr_t a,
                                input axi_write_bridge_pkg::data_t d,
                                input axi_write_bridge_pkg::strb_t s,
                                output logic err, output axi_write_bridge_pkg::data_t rd);
        // Setup phase
        wait_cycles(1);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = a;
        pwdata  = d;
        pstrb   = s;
        // Access phase until pready
        wait_cycles(1);
        penable = 1'b1;
        @(negedge clock);
        while (!pready) @(negedge clock);
        err = pslverr;
        rd  = prdata;
        wait_cycles(1);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Error expected whenever address bit 31 is set
    task automatic write_and_check(input axi_write_bridge_pkg::addr_t a,
                                   input axi_write_bridge_pkg::data_t d,
                                   input axi_write_bridge_pkg::strb_t s);
        int                          aw_before;
        logic                        err;
        axi_write_bridge_pkg::data_t rd;
        aw_before = aw_count;
        apb_transfer(1'b1, a, d, s, err, rd);
        compare_flag("aw_handshake", aw_count == aw_before + 1, 1'b1);
        compare_addr("awaddr", seen_addr, a);
        compare_data("wdata", seen_data, d);
        compare_strb("wstrb", seen_strb, s);
        compare_flag("pslverr", err, a[31]);
    endtask

    // --------------------
    // Directed tests
    task automatic basic_write_test();
        int start_errors;
        start_errors = errors;
        @(negedge clock);
        compare_flag("pready", pready, 1'b0);
        compare_flag("awvalid", awvalid, 1'b0);
        compare_flag("wvalid", wvalid, 1'b0);
        compare_flag("bready", bready, 1'b0);
        write_and_check(32'h0000_0100, 32'ha5a5_0f0f, 4'hf);
        report_test("basic_write", start_errors);
    endtask

    task automatic order_test();
        int                          start_errors;
        logic [31:0]                 r;
        axi_write_bridge_pkg::addr_t a;
        axi_write_bridge_pkg::strb_t s;
        start_errors = errors;
        for (int i = 0; i < 20; i++) begin
            r = lcg_next();
            a = {1'b0, r[30:0]};
            r = lcg_next();
            s = r[19:16];
            if (s == '0) s = 4'b0001;
            write_and_check(a, lcg_next(), s);
            compare_flag("aw_before_w", aw_cycle < w_cycle, 1'b1);
            compare_flag("w_before_b", w_cycle < b_cycle, 1'b1);
            compare_flag("b_before_pready", b_cycle < pready_cycle, 1'b1);
        end
        report_test("order_backpressure", start_errors);
    endtask

    task automatic error_response_test();
        int start_errors;
        start_errors = errors;
        // SLVERR, then DECERR, then OKAY
        write_and_check(32'h8000_0010, 32'h1111_2222, 4'hf);
        write_and_check(32'hc000_0020, 32'h3333_4444, 4'hf);
        write_and_check(32'h0000_0030, 32'h5555_6666, 4'hf);
        report_test("error_responses", start_errors);
    endtask

    task automatic read_test();
        int                          start_errors;
        int                          aw_before;
        logic                        err;
        axi_write_bridge_pkg::data_t rd;
        start_errors = errors;
        aw_before = aw_count;
        apb_transfer(1'b0, 32'h0000_0200, '0, '0, err, rd);
        compare_flag("pslverr", err, 1'b1);
        compare_data("prdata", rd, '0);
        compare_flag("aw_handshake", aw_count != aw_before, 1'b0);
        report_test("read", start_errors);
    endtask

    task automatic partial_strobe_test();
        int start_errors;
        start_errors = errors;
        write_and_check(32'h0000_0440, 32'hdead_beef, 4'b0101);
        report_test("partial_strobe", start_errors);
    endtask

    // --------------------
    // Sequence
    initial begin
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pstrb   = '0;
        repeat (2) @(posedge clock);
        #2 rst_n = 1'b1;
        basic_write_test();
        order_test();
        error_response_test();
        read_test();
        partial_strobe_test();
        $display("Tests: %0d passed, %0d failed, %0d mismatches",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
